/* hw/exec_pkg.sv */
// Shared definitions for the RV32I execute cluster
// Word size, ALU operations, opcodes and the instruction word views
`default_nettype none

package exec_pkg;

  parameter int WORD_SIZE = 32;                   // Data word width

  typedef logic [WORD_SIZE-1:0] word_t;           // One data word

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluop_t;

  // Major opcodes handled by the lanes
  parameter logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate

  // funct3 codes, shared by OP and OP-IMM
  parameter logic [2:0] F3_ADD  = 3'b000;         // add, sub, addi
  parameter logic [2:0] F3_SLL  = 3'b001;
  parameter logic [2:0] F3_SLT  = 3'b010;
  parameter logic [2:0] F3_SLTU = 3'b011;
  parameter logic [2:0] F3_XOR  = 3'b100;
  parameter logic [2:0] F3_SR   = 3'b101;         // srl and sra
  parameter logic [2:0] F3_OR   = 3'b110;
  parameter logic [2:0] F3_AND  = 3'b111;

  // funct7 codes
  parameter logic [6:0] F7_BASE = 7'b0000000;
  parameter logic [6:0] F7_ALT  = 7'b0100000;     // sub and sra

  // One instruction word, read as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;                         // Sign extended by the decoder
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_instr_u;

endpackage

`default_nettype wire

/* hw/alu.sv */
// Word ALU for RV32I integer operations
// One extended adder covers add, sub, slt and sltu
`default_nettype none

module alu (
  input  exec_pkg::aluop_t aluop,
  input  exec_pkg::word_t  port_a,
  input  exec_pkg::word_t  port_b,
  output exec_pkg::word_t  port_out
);

  localparam int W = exec_pkg::WORD_SIZE;

  logic         do_sub;                           // Adder subtracts
  logic         ext_a, ext_b;                     // Extension bits above the MSB
  logic [W:0]   op_a_ext, op_b_ext;               // Extended adder operands
  logic [W:0]   adder_out;                        // Sum including the extra bit
  logic         sign_a, sign_b, sign_r;
  logic         slt_bit, sltu_bit;
  logic [4:0]   shamt;                            // Shift amount, low 5 bits of b

  // Everything except add goes through the adder as a - b
  assign do_sub = (aluop != exec_pkg::ALU_ADD);

  // Zero extension for sltu, sign extension otherwise
  assign ext_a = (aluop == exec_pkg::ALU_SLTU) ? 1'b0 : port_a[W-1];
  assign ext_b = (aluop == exec_pkg::ALU_SLTU) ? 1'b0 : port_b[W-1];

  assign op_a_ext  = {ext_a, port_a};
  assign op_b_ext  = do_sub ? ~{ext_b, port_b} : {ext_b, port_b};  // Inverted, plus carry-in
  assign adder_out = op_a_ext + op_b_ext + (W + 1)'(do_sub);

  assign sign_a = port_a[W-1];
  assign sign_b = port_b[W-1];
  assign sign_r = adder_out[W-1];                 // Sign of a - b

  // Differing signs decide directly, else the difference sign does
  always_comb begin
    if (sign_a && !sign_b) begin
      slt_bit = 1'b1;                             // Negative below positive
    end else if (!sign_a && sign_b) begin
      slt_bit = 1'b0;
    end else begin
      slt_bit = sign_r;                           // No overflow with equal signs
    end
  end

  // Top bit of the zero-extended difference is the borrow, set when a < b
  assign sltu_bit = adder_out[W];

  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      exec_pkg::ALU_ADD  : port_out = adder_out[W-1:0];
      exec_pkg::ALU_SUB  : port_out = adder_out[W-1:0];
      exec_pkg::ALU_SLL  : port_out = port_a << shamt;
      exec_pkg::ALU_SRL  : port_out = port_a >> shamt;
      exec_pkg::ALU_SRA  : port_out = $signed(port_a) >>> shamt;  // Sign fill
      exec_pkg::ALU_AND  : port_out = port_a & port_b;
      exec_pkg::ALU_OR   : port_out = port_a | port_b;
      exec_pkg::ALU_XOR  : port_out = port_a ^ port_b;
      exec_pkg::ALU_SLT  : port_out = {{(W-1){1'b0}}, slt_bit};
      exec_pkg::ALU_SLTU : port_out = {{(W-1){1'b0}}, sltu_bit};
      default            : port_out = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/op_decoder.sv */
// Instruction decoder for the RV32I OP and OP-IMM groups
// Gives ALU operation, register indices, immediate and illegal flag
`default_nettype none

module op_decoder #(
  parameter int REG_ADDR_W = 5
) (
  input  exec_pkg::rv_instr_u    instr,
  output exec_pkg::aluop_t       aluop,
  output logic [REG_ADDR_W-1:0]  rs1,
  output logic [REG_ADDR_W-1:0]  rs2,
  output logic [REG_ADDR_W-1:0]  rd,
  output logic                   use_imm,
  output exec_pkg::word_t        imm,
  output logic                   illegal
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       f7_ok;                              // funct7 is zero or the alternate code

  assign opcode = instr.r.opcode;
  assign f3     = instr.r.funct3;
  assign f7     = instr.r.funct7;                 // Upper immediate bits for OP-IMM
  assign f7_ok  = (f7 == exec_pkg::F7_BASE) || (f7 == exec_pkg::F7_ALT);

  // Low bits only when the file is smaller than 32 entries
  assign rs1 = instr.r.rs1[REG_ADDR_W-1:0];
  assign rs2 = instr.r.rs2[REG_ADDR_W-1:0];
  assign rd  = instr.r.rd[REG_ADDR_W-1:0];

  assign imm = {{(exec_pkg::WORD_SIZE-12){instr.i.imm12[11]}}, instr.i.imm12};

  always_comb begin
    aluop   = exec_pkg::ALU_ADD;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (f3)                                     // Same mapping for both groups
      exec_pkg::F3_ADD  : aluop = exec_pkg::ALU_ADD;
      exec_pkg::F3_SLL  : aluop = exec_pkg::ALU_SLL;
      exec_pkg::F3_SLT  : aluop = exec_pkg::ALU_SLT;
      exec_pkg::F3_SLTU : aluop = exec_pkg::ALU_SLTU;
      exec_pkg::F3_XOR  : aluop = exec_pkg::ALU_XOR;
      exec_pkg::F3_SR   : aluop = f7[5] ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
      exec_pkg::F3_OR   : aluop = exec_pkg::ALU_OR;
      default           : aluop = exec_pkg::ALU_AND;
    endcase
    if (opcode == exec_pkg::OPC_OP) begin
      if (f3 == exec_pkg::F3_ADD && f7[5]) begin
        aluop = exec_pkg::ALU_SUB;                // sub only exists in OP
      end
      if (f3 == exec_pkg::F3_ADD || f3 == exec_pkg::F3_SR) begin
        illegal = !f7_ok;
      end else begin
        illegal = (f7 != exec_pkg::F7_BASE);
      end
    end else if (opcode == exec_pkg::OPC_OP_IMM) begin
      use_imm = 1'b1;
      if (f3 == exec_pkg::F3_SLL) begin
        illegal = (f7 != exec_pkg::F7_BASE);      // slli has no alternate form
      end else if (f3 == exec_pkg::F3_SR) begin
        illegal = !f7_ok;
      end
    end else begin
      illegal = 1'b1;                             // Opcode outside both groups
    end
  end

endmodule

`default_nettype wire

/* hw/exec_lane.sv */
// Execute lane holding one instruction until the register file is granted
// Reads, computes and writes in the grant cycle, then pulses done
`default_nettype none

module exec_lane #(
  parameter int REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_strobe,   // Accepted only when not busy
  input  exec_pkg::word_t       instr,
  output logic                  req,            // Held until granted
  input  logic                  gnt,
  output logic [REG_ADDR_W-1:0] rs1,
  output logic [REG_ADDR_W-1:0] rs2,
  input  exec_pkg::word_t       rd_data1,
  input  exec_pkg::word_t       rd_data2,
  output logic                  wr_en,
  output logic [REG_ADDR_W-1:0] wr_addr,
  output exec_pkg::word_t       wr_data,
  output logic                  busy,
  output logic                  done,
  output logic                  illegal,
  output exec_pkg::word_t       result
);

  exec_pkg::rv_instr_u   instr_q;               // Latched instruction word
  logic                  pending;               // Instruction waiting for its grant
  logic                  fire;                  // Grant cycle
  exec_pkg::aluop_t      aluop;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic                  use_imm;
  exec_pkg::word_t       imm;
  logic                  dec_illegal;
  exec_pkg::word_t       alu_b;
  exec_pkg::word_t       alu_out;

  op_decoder #(
    .REG_ADDR_W (REG_ADDR_W)
  ) u_dec (
    .instr   (instr_q),
    .aluop   (aluop),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (dec_rd),
    .use_imm (use_imm),
    .imm     (imm),
    .illegal (dec_illegal)
  );

  assign alu_b = use_imm ? imm : rd_data2;      // Immediate or rs2 data

  alu u_alu (
    .aluop    (aluop),
    .port_a   (rd_data1),
    .port_b   (alu_b),
    .port_out (alu_out)
  );

  assign req  = pending;
  assign busy = pending;
  assign fire = pending & gnt;

  // Write back in the grant cycle, never to x0 or for an illegal word
  assign wr_en   = fire && !dec_illegal && (dec_rd != '0);
  assign wr_addr = dec_rd;
  assign wr_data = alu_out;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
      done    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      done <= fire;                             // One-cycle pulse after the grant
      if (fire) begin
        pending <= 1'b0;                        // Free again in the done cycle
        illegal <= dec_illegal;
      end else if (instr_strobe && !pending) begin
        pending <= 1'b1;
      end
    end
  end

  // Payload, qualified by pending and done
  always_ff @(posedge clk) begin
    if (instr_strobe && !pending) begin
      instr_q <= instr;
    end
    if (fire) begin
      result <= alu_out;
    end
  end

endmodule

`default_nettype wire

/* hw/regfile_arbiter.sv */
// Round-robin arbiter for the shared register file
// Ties go to the lane not granted most recently
`default_nettype none

module regfile_arbiter (
  input  logic clk,
  input  logic arst_n,
  input  logic req0,
  input  logic req1,
  output logic gnt0,
  output logic gnt1
);

  logic last1;                                  // Lane 1 won the most recent grant

  // Single requester wins outright, else the other lane's turn
  assign gnt0 = req0 && (!req1 || last1);
  assign gnt1 = req1 && (!req0 || !last1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last1 <= 1'b1;                            // Lane 0 preferred after reset
    end else if (gnt0) begin
      last1 <= 1'b0;
    end else if (gnt1) begin
      last1 <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/regfile.sv */
// Integer register file, x0 reads as zero
// Two combinational read ports and one write port
`default_nettype none

module regfile #(
  parameter int REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [REG_ADDR_W-1:0] ra1,
  input  logic [REG_ADDR_W-1:0] ra2,
  output exec_pkg::word_t       rd1,
  output exec_pkg::word_t       rd2,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] wa,
  input  exec_pkg::word_t       wd
);

  localparam int DEPTH = 2 ** REG_ADDR_W;

  exec_pkg::word_t regs [DEPTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;                          // Whole file starts at zero
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;                           // x0 writes dropped
    end
  end

  // Reads see the old value during a same-cycle write
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* hw/exec_cluster.sv */
// Two-lane RV32I execute cluster sharing one register file
// The arbiter grant steers one lane's ports onto the file each cycle
`default_nettype none

module exec_cluster #(
  parameter int REG_ADDR_W = 5
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_strobe_0,
  input  exec_pkg::word_t instr_0,
  output logic            busy_0,
  output logic            done_0,
  output exec_pkg::word_t result_0,
  output logic            illegal_0,
  input  logic            instr_strobe_1,
  input  exec_pkg::word_t instr_1,
  output logic            busy_1,
  output logic            done_1,
  output exec_pkg::word_t result_1,
  output logic            illegal_1
);

  logic                  req0, req1;
  logic                  gnt0, gnt1;
  logic [REG_ADDR_W-1:0] rs1_0, rs2_0, rs1_1, rs2_1;
  logic                  wr_en_0, wr_en_1;
  logic [REG_ADDR_W-1:0] wr_addr_0, wr_addr_1;
  exec_pkg::word_t       wr_data_0, wr_data_1;
  logic [REG_ADDR_W-1:0] ra1, ra2, wa;         // Granted lane's file ports
  logic                  we;
  exec_pkg::word_t       wd;
  exec_pkg::word_t       rd1, rd2;              // Read data, to both lanes

  exec_lane #(.REG_ADDR_W(REG_ADDR_W)) lane0 (
    .clk (clk), .arst_n (arst_n), .instr_strobe (instr_strobe_0), .instr (instr_0),
    .req (req0), .gnt (gnt0), .rs1 (rs1_0), .rs2 (rs2_0),
    .rd_data1 (rd1), .rd_data2 (rd2),
    .wr_en (wr_en_0), .wr_addr (wr_addr_0), .wr_data (wr_data_0),
    .busy (busy_0), .done (done_0), .illegal (illegal_0), .result (result_0)
  );

  exec_lane #(.REG_ADDR_W(REG_ADDR_W)) lane1 (
    .clk (clk), .arst_n (arst_n), .instr_strobe (instr_strobe_1), .instr (instr_1),
    .req (req1), .gnt (gnt1), .rs1 (rs1_1), .rs2 (rs2_1),
    .rd_data1 (rd1), .rd_data2 (rd2),
    .wr_en (wr_en_1), .wr_addr (wr_addr_1), .wr_data (wr_data_1),
    .busy (busy_1), .done (done_1), .illegal (illegal_1), .result (result_1)
  );

  regfile_arbiter u_arb (
    .clk (clk), .arst_n (arst_n),
    .req0 (req0), .req1 (req1), .gnt0 (gnt0), .gnt1 (gnt1)
  );

  // Grant steers the file ports, write enables are already grant-qualified
  assign ra1 = gnt1 ? rs1_1 : rs1_0;
  assign ra2 = gnt1 ? rs2_1 : rs2_0;
  assign we  = wr_en_0 | wr_en_1;
  assign wa  = gnt1 ? wr_addr_1 : wr_addr_0;
  assign wd  = gnt1 ? wr_data_1 : wr_data_0;

  regfile #(.REG_ADDR_W(REG_ADDR_W)) u_rf (
    .clk (clk), .arst_n (arst_n),
    .ra1 (ra1), .ra2 (ra2), .rd1 (rd1), .rd2 (rd2),
    .we (we), .wa (wa), .wd (wd)
  );

endmodule

`default_nettype wire

/* bench/exec_cluster_checker.sv */
// Concurrent checks on register file grants and lane done pulses
// Bound into the execute cluster top level
`default_nettype none

module exec_cluster_checker (
  input logic clk,
  input logic arst_n,
  input logic req1,
  input logic gnt0,
  input logic gnt1,
  input logic done_0,
  input logic done_1
);
  timeunit 1ns;
  timeprecision 1ps;

  logic last_was_0;                               // Lane 0 holds the most recent grant

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_was_0 <= 1'b0;                         // Lane 0 preferred after reset
    end else if (gnt0) begin
      last_was_0 <= 1'b1;
    end else if (gnt1) begin
      last_was_0 <= 1'b0;
    end
  end

  // Only one lane owns the file per cycle
  grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) !(gnt0 && gnt1))
    else $error("Both lanes granted in one cycle");

  done_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(done_0 && done_1))
    else $error("Done pulses on both lanes together");

  // Waiting lane 1 gets the next turn
  round_robin: assert property (@(posedge clk) disable iff (!arst_n)
                                (last_was_0 && req1) |-> !gnt0)
    else $error("Lane 0 granted twice while lane 1 waited");

  done0_after_gnt: assert property (@(posedge clk) disable iff (!arst_n) done_0 |-> $past(gnt0))
    else $error("Lane 0 done without a grant the cycle before");

  done1_after_gnt: assert property (@(posedge clk) disable iff (!arst_n) done_1 |-> $past(gnt1))
    else $error("Lane 1 done without a grant the cycle before");

endmodule

bind exec_cluster exec_cluster_checker u_chk (
  .clk (clk), .arst_n (arst_n), .req1 (req1), .gnt0 (gnt0), .gnt1 (gnt1),
  .done_0 (done_0), .done_1 (done_1)
);

`default_nettype wire

/* bench/exec_cluster_tb.sv */
// Testbench for the two-lane execute cluster
// Table driven stimulus, software register model, checks and summary
`default_nettype none

module exec_cluster_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic arst_n, instr_strobe_0, instr_strobe_1;
  exec_pkg::word_t instr_0, instr_1, result_0, result_1;
  logic busy_0, busy_1, done_0, done_1, illegal_0, illegal_1;

  logic [1:0]  t_mask[$];                          // 01 lane 0, 10 lane 1, 11 pair with next
  logic        t_dual[$];                          // Strobe repeated while busy
  logic [31:0] t_instr[$];
  logic        table_built = 1'b0;                 // Stimulus table complete
  logic [31:0] model[32];                          // Register state in done order
  logic [31:0] pend[2];                            // Word in flight per lane
  integer      seed = 32'h57b1_6734;
  int errors = 0, tests = 0, bad_tests = 0;

  exec_cluster #(.REG_ADDR_W(5)) UUT (
    .clk (clk), .arst_n (arst_n),
    .instr_strobe_0 (instr_strobe_0), .instr_0 (instr_0), .busy_0 (busy_0),
    .done_0 (done_0), .result_0 (result_0), .illegal_0 (illegal_0),
    .instr_strobe_1 (instr_strobe_1), .instr_1 (instr_1), .busy_1 (busy_1),
    .done_1 (done_1), .result_1 (result_1), .illegal_1 (illegal_1)
  );

  always #20 clk = ~clk;                           // 40 ns period

  function automatic logic [31:0] r_word(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    exec_pkg::rv_instr_u u;
    u.r = '{f7, 5'(rs2), 5'(rs1), f3, 5'(rd), exec_pkg::OPC_OP};
    return u;
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input int rs1,
                                         input logic [2:0] f3, input int rd);
    exec_pkg::rv_instr_u u;
    u.i = '{imm, 5'(rs1), f3, 5'(rd), exec_pkg::OPC_OP_IMM};
    return u;
  endfunction

  // RISC-V semantics on the model give {illegal, result}
  function automatic logic [32:0] ref_exec(input logic [31:0] w);
    logic [6:0]  opc, f7;
    logic [2:0]  f3;
    logic [31:0] a, b, r;
    logic        bad;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = model[w[19:15]];
    b   = (opc == exec_pkg::OPC_OP) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (opc == exec_pkg::OPC_OP) begin
      bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    end else if (opc == exec_pkg::OPC_OP_IMM) begin
      bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
    end else begin
      bad = 1'b1;
    end
    case (f3)
      3'd0: r = (opc == exec_pkg::OPC_OP && f7[5]) ? a - b : a + b;
      3'd1: r = a << b[4:0];                       // Only the low 5 bits shift
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: r = f7[5] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return {bad, r};
  endfunction

  task automatic add_entry(input logic [1:0] mask, input logic dual, input logic [31:0] w);
    t_mask.push_back(mask);
    t_dual.push_back(dual);
    t_instr.push_back(w);
  endtask

  // Compare one done event with the model, then retire it
  task automatic check_done(input int lane);
    logic [32:0] exp;
    logic [31:0] res;
    logic        ill;
    logic        bsy;
    exp = ref_exec(pend[lane]);
    res = lane ? result_1 : result_0;
    ill = lane ? illegal_1 : illegal_0;
    bsy = lane ? busy_1 : busy_0;
    assert (!bsy) else begin
      $display("error at %0t: lane %0d still busy in its done cycle", $time, lane);
      errors++;
    end
    assert (ill == exp[32]) else begin
      $display("error at %0t: lane %0d illegal %0b, expected %0b", $time, lane, ill, exp[32]);
      errors++;
    end
    if (!exp[32]) begin
      assert (res == exp[31:0]) else begin
        $display("error at %0t: lane %0d result %h, expected %h", $time, lane, res, exp[31:0]);
        errors++;
      end
      if (pend[lane][11:7] != 5'd0) model[pend[lane][11:7]] = exp[31:0];
    end
  endtask

  task automatic run_group(input int i, output int used);
    int want, seen, waited, err0;
    logic [1:0] mask;
    logic [1:0] waiting;                           // Lanes still owing a done
    err0 = errors;
    mask = t_mask[i];
    waiting = mask;
    seen = 0;
    waited = 0;
    used = (mask == 2'b11) ? 2 : 1;
    want = used;
    @(posedge clk);
    if (mask == 2'b11) begin
      pend[0] = t_instr[i];
      pend[1] = t_instr[i+1];
    end else begin
      pend[mask[1]] = t_instr[i];
    end
    instr_0 <= pend[0];
    instr_1 <= pend[1];
    instr_strobe_0 <= mask[0];
    instr_strobe_1 <= mask[1];
    @(posedge clk);
    if (t_dual[i]) @(posedge clk);                 // Second strobe lands while busy
    instr_strobe_0 <= 1'b0;
    instr_strobe_1 <= 1'b0;
    while (seen < want && waited < 8) begin
      @(negedge clk);
      waited++;
      assert (!(done_0 && done_1)) else begin
        $display("error at %0t: done on both lanes in one cycle", $time);
        errors++;
      end
      if (done_0) begin
        check_done(0);
        seen++;
        waiting[0] = 1'b0;
      end
      if (done_1) begin
        check_done(1);
        seen++;
        waiting[1] = 1'b0;
      end
      assert (!(waiting[0] && !busy_0) && !(waiting[1] && !busy_1)) else begin
        $display("error at %0t: busy low while a lane waits for done", $time);
        errors++;
      end
    end
    if (seen < want) begin
      $display("Entry %0d never reported done within 8 cycles", i);
      errors++;
    end
    if (t_dual[i]) begin
      repeat (2) begin
        @(negedge clk);
        assert (!done_0 && !done_1) else begin
          $display("error at %0t: extra done after a strobe while busy", $time);
          errors++;
        end
      end
    end
    tests++;
    if (errors != err0) bad_tests++;
    $display("test %0d entry %0d mask %b: %s", tests, i, mask, (errors == err0) ? "ok" : "FAIL");
  endtask

  initial begin
    wait (table_built);
    #(t_instr.size() * 4 * 40 + 16 * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("Test failed");
    $finish;
  end

  initial begin
    int idx, used;
    arst_n = 1'b0;
    instr_strobe_0 = 1'b0;
    instr_strobe_1 = 1'b0;
    instr_0 = '0;
    instr_1 = '0;
    foreach (model[k]) model[k] = '0;
    pend[0] = '0;
    pend[1] = '0;
    add_entry(2'b01, 0, r_word(7'h00, 0, 7, 3'd0, 1));   // Fresh file reads zero
    add_entry(2'b10, 0, r_word(7'h00, 31, 0, 3'd0, 2));
    for (int r = 1; r <= 6; r++) begin
      add_entry(r[0] ? 2'b01 : 2'b10, 0, i_word(12'($random(seed)), 0, 3'd0, r));
    end
    add_entry(2'b01, 0, i_word(12'hfff, 0, 3'd0, 7));     // x7 = -1
    add_entry(2'b10, 0, i_word(12'h005, 0, 3'd0, 8));
    add_entry(2'b01, 0, i_word(12'h7e5, 0, 3'd0, 13));    // Shift count 5 in low bits
    add_entry(2'b01, 0, r_word(7'h00, 2, 1, 3'd0, 9));
    add_entry(2'b01, 0, r_word(7'h20, 8, 0, 3'd0, 10));   // 0 - 5 wraps
    add_entry(2'b10, 0, r_word(7'h20, 7, 8, 3'd0, 11));
    add_entry(2'b01, 0, r_word(7'h00, 13, 1, 3'd1, 12));
    add_entry(2'b10, 0, r_word(7'h00, 13, 7, 3'd5, 14));
    add_entry(2'b01, 0, r_word(7'h20, 13, 7, 3'd5, 15));
    add_entry(2'b01, 0, r_word(7'h00, 8, 7, 3'd2, 16));   // Mixed signs
    add_entry(2'b10, 0, r_word(7'h00, 8, 7, 3'd3, 17));
    add_entry(2'b01, 0, r_word(7'h00, 2, 1, 3'd4, 18));
    add_entry(2'b01, 0, r_word(7'h00, 3, 1, 3'd6, 19));
    add_entry(2'b10, 0, r_word(7'h00, 4, 1, 3'd7, 20));
    add_entry(2'b01, 0, i_word(12'hffd, 8, 3'd2, 21));
    add_entry(2'b10, 0, i_word(12'hffd, 8, 3'd3, 22));
    add_entry(2'b01, 0, i_word(12'h5a5, 1, 3'd4, 23));
    add_entry(2'b01, 0, i_word(12'h0f0, 2, 3'd6, 24));
    add_entry(2'b10, 0, i_word(12'h70f, 3, 3'd7, 25));
    add_entry(2'b01, 0, i_word(12'h01f, 1, 3'd1, 26));
    add_entry(2'b01, 0, i_word(12'h004, 7, 3'd5, 27));
    add_entry(2'b10, 0, i_word(12'h407, 7, 3'd5, 28));    // srai on -1
    add_entry(2'b01, 0, i_word(12'h403, 10, 3'd5, 29));
    add_entry(2'b01, 0, i_word(12'h07b, 1, 3'd0, 0));     // Dropped write to x0
    add_entry(2'b10, 0, r_word(7'h00, 0, 0, 3'd0, 30));
    add_entry(2'b11, 0, r_word(7'h00, 2, 1, 3'd0, 24));   // Pair where lane 1 reads x24
    add_entry(2'b11, 0, r_word(7'h20, 3, 24, 3'd0, 25));
    add_entry(2'b01, 0, r_word(7'h00, 0, 25, 3'd0, 31));  // Lane 1 wins the next tie
    add_entry(2'b11, 0, r_word(7'h00, 5, 2, 3'd4, 2));
    add_entry(2'b11, 0, r_word(7'h00, 0, 2, 3'd0, 26));
    add_entry(2'b01, 0, {25'h0000_0c3, 7'b0000011});       // Load opcode is illegal
    add_entry(2'b10, 0, r_word(7'h01, 2, 1, 3'd0, 3));    // Bad funct7
    add_entry(2'b01, 0, r_word(7'h00, 0, 1, 3'd0, 27));   // Read back after illegal
    add_entry(2'b10, 0, r_word(7'h00, 0, 3, 3'd0, 28));
    add_entry(2'b01, 1, i_word(12'h001, 28, 3'd0, 28));   // Strobe again while busy
    table_built = 1'b1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (!busy_0 && !busy_1 && !done_0 && !done_1 && !illegal_0 && !illegal_1) else begin
      $display("error at %0t: lane outputs not idle after reset", $time);
      errors++;
    end
    idx = 0;
    while (idx < t_instr.size()) begin
      run_group(idx, used);
      idx += used;
    end
    $display("%0d tests, %0d failed, %0d errors", tests, bad_tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/exec_pkg.sv
hw/alu.sv
hw/op_decoder.sv
hw/exec_lane.sv
hw/regfile_arbiter.sv
hw/regfile.sv
hw/exec_cluster.sv
bench/exec_cluster_checker.sv
bench/exec_cluster_tb.sv

/* run.sh */
#!/bin/sh
# Build the execute cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module exec_cluster_tb -o exec_cluster_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/exec_cluster_sim > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
